// ==== Makefile ====
# Verilator flow for the beamforming adder

VERILATOR  ?= verilator
TOP        ?= beam_adder_tb
RTL_TOP    ?= beam_adder
FILELIST   ?= beam_adder.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/100ps
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE) -j $(JOBS)
LINT_FLAGS ?= --lint-only --timescale $(TIMESCALE)
SIM_ARGS   ?= +verilator+error+limit+100
PASS_MSG   ?= Test completed successfully

RTL_FILES  := $(shell grep '^rtl/' $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-o V$(TOP) -f $(FILELIST)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== beam_adder.f ====
rtl/beam_pkg.sv
rtl/beam_ingress.sv
rtl/beam_weight_lane.sv
rtl/beam_combiner.sv
rtl/beam_adder.sv
test/beam_adder_assertions.sv
test/beam_adder_tb.sv

// ==== rtl/beam_adder.sv ====
// beamforming adder top that chains ingress, four weight lanes and the combiner
module beam_adder (
    input  logic                   clock,
    input  logic                   resetn,

    // eight sample streams, a real and an imaginary one per channel
    input  beam_pkg::sample_vec_t  s_real_data [beam_pkg::num_channels],
    input  beam_pkg::sample_vec_t  s_imag_data [beam_pkg::num_channels],
    input  logic [beam_pkg::num_channels-1:0] s_real_last,
    input  logic [beam_pkg::num_channels-1:0] s_real_valid,
    input  logic [beam_pkg::num_channels-1:0] s_imag_valid,
    output logic [beam_pkg::num_channels-1:0] s_real_ready,
    output logic [beam_pkg::num_channels-1:0] s_imag_ready,

    // complex weight per channel, taken as a level
    input  beam_pkg::cweight_t     weights [beam_pkg::num_channels],

    // combined complex output stream
    output beam_pkg::cbeat_t       m_data,
    output logic                   m_last,
    output logic                   m_valid,
    input  logic                   m_ready
);
    import beam_pkg::*;

    // single stall signal shared by every stage
    logic     advance;
    lane_in_t lane_in [num_channels];
    cbeat_t   lane_out [num_channels];

    beam_ingress u_ingress (
        .clock        (clock),
        .resetn       (resetn),
        .advance      (advance),
        .s_real_data  (s_real_data),
        .s_imag_data  (s_imag_data),
        .s_real_last  (s_real_last),
        .s_real_valid (s_real_valid),
        .s_imag_valid (s_imag_valid),
        .weights      (weights),
        .s_real_ready (s_real_ready),
        .s_imag_ready (s_imag_ready),
        .lanes        (lane_in)
    );

    // one lane per antenna channel
    for (genvar c = 0; c < num_channels; c++) begin : g_lane
        beam_weight_lane u_lane (
            .clock    (clock),
            .resetn   (resetn),
            .advance  (advance),
            .lane_in  (lane_in[c]),
            .lane_out (lane_out[c])
        );
    end

    beam_combiner u_combiner (
        .clock   (clock),
        .resetn  (resetn),
        .lanes   (lane_out),
        .m_ready (m_ready),
        .advance (advance),
        .m_data  (m_data),
        .m_last  (m_last),
        .m_valid (m_valid)
    );

endmodule

// ==== rtl/beam_combiner.sv ====
// beamformer combiner that averages the four weighted lanes and owns the output register
module beam_combiner (
    input  logic             clock,
    input  logic             resetn,
    input  beam_pkg::cbeat_t lanes [beam_pkg::num_channels],
    input  logic             m_ready,
    output logic             advance,
    output beam_pkg::cbeat_t m_data,
    output logic             m_last,
    output logic             m_valid
);
    import beam_pkg::*;

    sample_vec_t avg_re;
    sample_vec_t avg_im;
    logic        valid_q;
    logic        last_q;
    sample_vec_t re_q;
    sample_vec_t im_q;

    // adds one sample position across all lanes, rounds and divides by the lane count
    // the result is always within the sample range, so no clamp is needed
    function automatic sample_t lane_average(input sample_t vals [num_channels]);
        comb_sum_t sum;
        comb_sum_t avg;
        sum = comb_sum_t'(comb_round);
        for (int c = 0; c < num_channels; c++) begin
            sum = sum + comb_sum_t'(vals[c]);
        end
        avg = sum >>> sum_shift;
        return avg[sample_width-1:0];
    endfunction

    always_comb begin
        sample_t vals_re [num_channels];
        sample_t vals_im [num_channels];
        for (int i = 0; i < samples_per_beat; i++) begin
            for (int c = 0; c < num_channels; c++) begin
                vals_re[c] = lanes[c].re[i*sample_width +: sample_width];
                vals_im[c] = lanes[c].im[i*sample_width +: sample_width];
            end
            avg_re[i*sample_width +: sample_width] = lane_average(vals_re);
            avg_im[i*sample_width +: sample_width] = lane_average(vals_im);
        end
    end

    // the whole pipeline moves when the output slot is free or being drained
    assign advance = !valid_q || m_ready;

    // all lanes carry the same valid and last, lane 0 stands for them
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= lanes[0].valid;
        end
    end

    // output payload is held steady while the sink stalls
    always_ff @(posedge clock) begin
        if (advance) begin
            last_q <= lanes[0].last;
            re_q   <= avg_re;
            im_q   <= avg_im;
        end
    end

    assign m_valid = valid_q;
    assign m_last  = last_q;
    assign m_data  = '{valid: valid_q, last: last_q, re: re_q, im: im_q};

endmodule

// ==== rtl/beam_ingress.sv ====
// beamformer ingress that joins the eight input streams and captures one beat per channel
module beam_ingress (
    input  logic                   clock,
    input  logic                   resetn,
    input  logic                   advance,
    input  beam_pkg::sample_vec_t  s_real_data [beam_pkg::num_channels],
    input  beam_pkg::sample_vec_t  s_imag_data [beam_pkg::num_channels],
    input  logic [beam_pkg::num_channels-1:0] s_real_last,
    input  logic [beam_pkg::num_channels-1:0] s_real_valid,
    input  logic [beam_pkg::num_channels-1:0] s_imag_valid,
    input  beam_pkg::cweight_t     weights [beam_pkg::num_channels],
    output logic [beam_pkg::num_channels-1:0] s_real_ready,
    output logic [beam_pkg::num_channels-1:0] s_imag_ready,
    output beam_pkg::lane_in_t     lanes [beam_pkg::num_channels]
);
    import beam_pkg::*;

    logic        all_valid;
    logic        accept;
    logic        valid_q;
    logic        last_q;
    sample_vec_t re_q [num_channels];
    sample_vec_t im_q [num_channels];
    cweight_t    weight_q [num_channels];

    // a beat is only taken when every real and imaginary stream offers one
    assign all_valid = (&s_real_valid) & (&s_imag_valid);

    // all streams move together, so a single accept serves every ready
    assign accept = advance & all_valid;
    assign s_real_ready = {num_channels{accept}};
    assign s_imag_ready = {num_channels{accept}};

    // the stage valid records whether the last advance actually took a beat
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= accept;
        end
    end

    // samples and weight are latched together so that a weight change
    // lands exactly on a beat boundary
    always_ff @(posedge clock) begin
        if (advance) begin
            // only channel 0's real stream defines the frame end
            last_q <= s_real_last[0];
            for (int c = 0; c < num_channels; c++) begin
                re_q[c]     <= s_real_data[c];
                im_q[c]     <= s_imag_data[c];
                weight_q[c] <= weights[c];
            end
        end
    end

    // every lane sees the same valid and last, only the payload differs
    always_comb begin
        for (int c = 0; c < num_channels; c++) begin
            lanes[c] = '{
                beat:   '{valid: valid_q, last: last_q, re: re_q[c], im: im_q[c]},
                weight: weight_q[c]
            };
        end
    end

endmodule

// ==== rtl/beam_pkg.sv ====
// beamformer package holding the widths, sample and weight types and beat structs
package beam_pkg;

    // antenna channels that are weighted and summed
    localparam int num_channels = 4;

    // samples carried side by side in one stream beat
    localparam int samples_per_beat = 16;

    // a sample is a signed 8-bit value
    localparam int sample_width = 8;

    // a weight part is signed with 8 fraction bits, so 255 is just under 1.0
    localparam int weight_width = 9;
    localparam int weight_frac_bits = 8;

    // the channel sum is averaged by this shift
    localparam int sum_shift = $clog2(num_channels);

    // one signed product of a sample and a weight part
    localparam int product_width = sample_width + weight_width;

    // the lane adds two products, which needs one more bit
    localparam int lane_acc_width = product_width + 1;

    // four 8-bit values plus the rounding constant fit in 10 bits
    localparam int comb_sum_width = sample_width + sum_shift;

    // half an LSB at each rounding point, for round to nearest
    localparam int lane_round = 1 << (weight_frac_bits - 1);
    localparam int comb_round = 1 << (sum_shift - 1);

    // limits that a weighted sample is clamped to
    localparam int sample_max = (1 << (sample_width - 1)) - 1;
    localparam int sample_min = -(1 << (sample_width - 1));

    typedef logic signed [sample_width-1:0] sample_t;
    typedef logic signed [weight_width-1:0] weight_t;
    typedef logic signed [lane_acc_width-1:0] lane_acc_t;
    typedef logic signed [comb_sum_width-1:0] comb_sum_t;

    // one beat of samples, sample 0 in the low byte
    typedef logic [samples_per_beat*sample_width-1:0] sample_vec_t;

    // complex weight of one channel
    typedef struct packed {
        weight_t re;
        weight_t im;
    } cweight_t;

    // complex beat as it moves between the pipeline stages
    typedef struct packed {
        logic        valid;
        logic        last;
        sample_vec_t re;
        sample_vec_t im;
    } cbeat_t;

    // what ingress hands to a weight lane, the beat with the weight it was taken with
    typedef struct packed {
        cbeat_t   beat;
        cweight_t weight;
    } lane_in_t;

endpackage

// ==== rtl/beam_weight_lane.sv ====
// beamformer weight lane that applies one channel's complex weight with rounding and saturation
module beam_weight_lane (
    input  logic               clock,
    input  logic               resetn,
    input  logic               advance,
    input  beam_pkg::lane_in_t lane_in,
    output beam_pkg::cbeat_t   lane_out
);
    import beam_pkg::*;

    sample_vec_t wt_re;
    sample_vec_t wt_im;
    logic        valid_q;
    logic        last_q;
    sample_vec_t re_q;
    sample_vec_t im_q;

    // rounds to nearest at the weight's binary point and clamps to a sample
    function automatic sample_t round_sat(input lane_acc_t acc);
        lane_acc_t rounded;
        rounded = (acc + lane_acc_t'(lane_round)) >>> weight_frac_bits;
        if (rounded > lane_acc_t'(sample_max)) begin
            return sample_t'(sample_max);
        end else if (rounded < lane_acc_t'(sample_min)) begin
            return sample_t'(sample_min);
        end
        return rounded[sample_width-1:0];
    endfunction

    // complex product per sample position
    // re = wr*xr - wi*xi and im = wi*xr + wr*xi
    always_comb begin
        sample_t   x_re;
        sample_t   x_im;
        lane_acc_t acc_re;
        lane_acc_t acc_im;
        for (int i = 0; i < samples_per_beat; i++) begin
            x_re = lane_in.beat.re[i*sample_width +: sample_width];
            x_im = lane_in.beat.im[i*sample_width +: sample_width];
            // both operands are widened as signed values before the multiply
            acc_re = lane_acc_t'(lane_in.weight.re) * lane_acc_t'(x_re)
                   - lane_acc_t'(lane_in.weight.im) * lane_acc_t'(x_im);
            acc_im = lane_acc_t'(lane_in.weight.im) * lane_acc_t'(x_re)
                   + lane_acc_t'(lane_in.weight.re) * lane_acc_t'(x_im);
            wt_re[i*sample_width +: sample_width] = round_sat(acc_re);
            wt_im[i*sample_width +: sample_width] = round_sat(acc_im);
        end
    end

    // valid moves with the pipeline, an empty slot stays empty
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= lane_in.beat.valid;
        end
    end

    // weighted payload, last is passed through untouched
    always_ff @(posedge clock) begin
        if (advance) begin
            last_q <= lane_in.beat.last;
            re_q   <= wt_re;
            im_q   <= wt_im;
        end
    end

    assign lane_out = '{valid: valid_q, last: last_q, re: re_q, im: im_q};

endmodule

// ==== test/beam_adder_assertions.sv ====
// protocol checker for the beamforming adder top covering reset, stall and ready rules
module beam_adder_assertions (
    input logic                              clock,
    input logic                              resetn,
    input logic [beam_pkg::num_channels-1:0] s_real_valid,
    input logic [beam_pkg::num_channels-1:0] s_imag_valid,
    input logic [beam_pkg::num_channels-1:0] s_real_ready,
    input logic [beam_pkg::num_channels-1:0] s_imag_ready,
    input beam_pkg::cbeat_t                  m_data,
    input logic                              m_valid,
    input logic                              m_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    // the output register comes out of reset empty
    assert property (@(posedge clock) $rose(resetn) |-> !m_valid)
        else $error("m_valid was high in the first cycle after reset");

    // a stalled output beat must be held unchanged until the sink takes it
    assert property (@(posedge clock) disable iff (!resetn)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data)))
        else $error("output beat dropped or changed while m_ready was low");

    // every stream transfers in the same cycle or none does
    assert property (@(posedge clock) disable iff (!resetn)
        (|{s_real_ready, s_imag_ready}) |->
            (&{s_real_ready, s_imag_ready, s_real_valid, s_imag_valid}))
        else $error("ready raised without every stream valid and ready together");

endmodule

bind beam_adder beam_adder_assertions u_assertions (
    .clock        (clock),
    .resetn       (resetn),
    .s_real_valid (s_real_valid),
    .s_imag_valid (s_imag_valid),
    .s_real_ready (s_real_ready),
    .s_imag_ready (s_imag_ready),
    .m_data       (m_data),
    .m_valid      (m_valid),
    .m_ready      (m_ready)
);

// ==== test/beam_adder_tb.sv ====
// testbench for the beamforming adder that replays a command trace against a reference model
module beam_adder_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import beam_pkg::*;

    logic                    clock = 1'b0;
    logic                    resetn;
    sample_vec_t             s_real_data [num_channels];
    sample_vec_t             s_imag_data [num_channels];
    logic [num_channels-1:0] s_real_last;
    logic [num_channels-1:0] s_real_valid;
    logic [num_channels-1:0] s_imag_valid;
    logic [num_channels-1:0] s_real_ready;
    logic [num_channels-1:0] s_imag_ready;
    cweight_t                weights [num_channels];
    cbeat_t                  m_data;
    logic                    m_last;
    logic                    m_valid;
    logic                    m_ready;

    // model copy of the weights and of the beat being offered
    int     w_re [num_channels];
    int     w_im [num_channels];
    int     base_re [num_channels];
    int     base_im [num_channels];
    int     beat_last;
    int     hold;
    // percentage of cycles in which the sink refuses a beat
    int     bp_pct = 0;
    cbeat_t expected_q [$];
    string  cmds [$];
    int     value_errors = 0;
    int     proto_errors = 0;
    int     cycles = 0;
    int     cycle_limit = 100000;
    int     beats_out = 0;
    logic   held = 1'b0;
    cbeat_t held_data;

    beam_adder DUT (.*);

    always #2 clock = ~clock;

    // the run is limited to a cycle count that is set once the trace length is known
    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d expected beats never came out",
                     cycles, expected_q.size());
            $display("Test failed");
            $finish;
        end
    end

    // random back-pressure whose percentage is switched by the trace
    always @(negedge clock) begin
        m_ready = ($urandom_range(99) >= bp_pct);
    end

    // wraps a value to a signed 8-bit sample
    function automatic int wrap8(input int v);
        int w;
        w = v & 255;
        if (w > 127) begin
            w = w - 256;
        end
        return w;
    endfunction

    // round to nearest at 8 fraction bits, then clamp to the sample range
    function automatic int round_clamp(input int acc);
        int r;
        r = (acc + 128) >>> 8;
        if (r > 127) begin
            r = 127;
        end else if (r < -128) begin
            r = -128;
        end
        return r;
    endfunction

    // expected output for the beat on the inputs with the weights now applied
    function automatic cbeat_t model_beat();
        cbeat_t b;
        int     xr;
        int     xi;
        int     sr;
        int     si;
        b = '0;
        b.valid = 1'b1;
        b.last = (beat_last != 0);
        for (int i = 0; i < samples_per_beat; i++) begin
            sr = 0;
            si = 0;
            for (int c = 0; c < num_channels; c++) begin
                xr = wrap8(base_re[c] + i);
                xi = wrap8(base_im[c] + i);
                sr += round_clamp(w_re[c] * xr - w_im[c] * xi);
                si += round_clamp(w_im[c] * xr + w_re[c] * xi);
            end
            // rounded average of the four channels
            b.re[i*sample_width +: sample_width] = 8'((sr + 2) >>> 2);
            b.im[i*sample_width +: sample_width] = 8'((si + 2) >>> 2);
        end
        return b;
    endfunction

    // output side checks sample at the rising edge before any register updates
    always @(posedge clock) begin
        cbeat_t want;
        if (resetn) begin
            if (held && m_data !== held_data) begin
                $display("m_data changed at %0t while the output was stalled", $time);
                proto_errors++;
            end
            if ((|{s_real_ready, s_imag_ready}) &&
                !(&{s_real_ready, s_imag_ready, s_real_valid, s_imag_valid})) begin
                $display("ready bits disagree across the input streams at %0t", $time);
                proto_errors++;
            end
            if (m_valid && m_ready) begin
                if (expected_q.size() == 0) begin
                    $display("output beat at %0t with no accepted beat pending", $time);
                    proto_errors++;
                end else begin
                    want = expected_q.pop_front();
                    if (m_data.re !== want.re) begin
                        $display("FAIL %0t: beat %0d real part got %h expected %h",
                                 $time, beats_out, m_data.re, want.re);
                        value_errors++;
                    end
                    if (m_data.im !== want.im) begin
                        $display("FAIL %0t: beat %0d imaginary part got %h expected %h",
                                 $time, beats_out, m_data.im, want.im);
                        value_errors++;
                    end
                    if (m_last !== want.last || m_data.last !== want.last) begin
                        $display("FAIL %0t: beat %0d last got %b and %b expected %b",
                                 $time, beats_out, m_last, m_data.last, want.last);
                        value_errors++;
                    end
                    beats_out++;
                end
            end
            held = m_valid && !m_ready;
            held_data = m_data;
        end
    end

    task automatic read_trace();
        int    fd;
        string line;
        fd = $fopen("test/beam_adder_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file test/beam_adder_trace.txt");
            proto_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                    cmds.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic set_weight(input string line);
        int ch;
        int re;
        int im;
        if ($sscanf(line, "W %d %d %d", ch, re, im) != 3) begin
            $display("malformed weight line in trace: %s", line);
            proto_errors++;
        end else begin
            w_re[ch] = re;
            w_im[ch] = im;
            weights[ch] = '{re: weight_t'(re), im: weight_t'(im)};
        end
    endtask

    // offers one beat, withholds one valid for the hold count, then waits for the handshake
    task automatic send_beat(input string line);
        int n;
        int k;
        n = $sscanf(line, "B %d %d %d %d %d %d %d %d %d %d", base_re[0], base_im[0],
                    base_re[1], base_im[1], base_re[2], base_im[2], base_re[3], base_im[3],
                    beat_last, hold);
        if (n != 10) begin
            $display("malformed beat line in trace: %s", line);
            proto_errors++;
        end else begin
            for (int c = 0; c < num_channels; c++) begin
                for (int i = 0; i < samples_per_beat; i++) begin
                    s_real_data[c][i*sample_width +: sample_width] = 8'(base_re[c] + i);
                    s_imag_data[c][i*sample_width +: sample_width] = 8'(base_im[c] + i);
                end
                // only channel 0 carries the real last and the others carry noise
                s_real_last[c] = 1'($urandom);
            end
            s_real_last[0] = (beat_last != 0);
            k = $urandom_range(2 * num_channels - 1);
            s_real_valid = '1;
            s_imag_valid = '1;
            if (k < num_channels) begin
                s_real_valid[k] = 1'b0;
            end else begin
                s_imag_valid[k - num_channels] = 1'b0;
            end
            repeat (hold) begin
                @(posedge clock);
                if (s_real_ready != '0 || s_imag_ready != '0) begin
                    $display("ready went high at %0t while a valid was withheld", $time);
                    proto_errors++;
                end
                @(negedge clock);
            end
            s_real_valid = '1;
            s_imag_valid = '1;
            do begin
                @(posedge clock);
            end while (s_real_ready[0] !== 1'b1);
            expected_q.push_back(model_beat());
            @(negedge clock);
            s_real_valid = '0;
            s_imag_valid = '0;
        end
    endtask

    initial begin
        string line;
        void'($urandom(32'he14d));
        resetn = 1'b0;
        m_ready = 1'b1;
        s_real_last = '0;
        s_real_valid = '0;
        s_imag_valid = '0;
        for (int c = 0; c < num_channels; c++) begin
            s_real_data[c] = '0;
            s_imag_data[c] = '0;
            weights[c] = '0;
            w_re[c] = 0;
            w_im[c] = 0;
        end
        read_trace();
        cycle_limit = 40 * cmds.size() + 100;
        repeat (4) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;
        foreach (cmds[j]) begin
            line = cmds[j];
            case (line[0])
                "W": set_weight(line);
                "B": send_beat(line);
                "P": begin
                    if ($sscanf(line, "P %d", bp_pct) != 1) begin
                        $display("malformed pressure line in trace: %s", line);
                        proto_errors++;
                    end
                end
                default: begin
                    $display("unknown command in trace: %s", line);
                    proto_errors++;
                end
            endcase
        end
        // drain with the sink always ready and stop after a short timeout
        bp_pct = 0;
        for (int t = 0; t < 20 && expected_q.size() != 0; t++) begin
            @(negedge clock);
        end
        if (expected_q.size() != 0) begin
            $display("%0d accepted beats never reached the output", expected_q.size());
            proto_errors++;
        end
        // a few idle cycles to catch any stray output beat
        repeat (4) @(negedge clock);
        $display("errors: %0d value, %0d protocol, %0d beats checked",
                 value_errors, proto_errors, beats_out);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== test/beam_adder_trace.txt ====
# W channel weight_re weight_im (signed, 8 fraction bits)   P percent of cycles with m_ready low
# B re0 im0 re1 im1 re2 im2 re3 im3 last hold (sample i of a stream is its base plus i)
P 0
W 0 255 0
W 1 0 0
W 2 0 0
W 3 0 0
B 0 -8 10 20 30 40 50 60 0 3
B -128 112 5 5 5 5 5 5 1 0
W 0 -180 90
W 1 -200 100
W 2 150 -255
W 3 -256 -256
B 100 -100 -50 60 120 -120 -128 127 0 2
B -30 40 70 -90 10 -10 -100 80 1 1
P 40
B 7 -7 33 -33 64 -64 -120 120 0 0
B 90 -60 -90 60 45 15 -15 -45 0 2
W 0 255 -255
B 90 -60 -90 60 45 15 -15 -45 1 0
P 70
B -1 1 2 -2 3 -3 4 -4 0 4
B 127 -128 -128 127 0 0 55 -55 1 0
